// File: hw/free_list.sv
////////////////////////////////////////
// Ring of free physical registers with one head and count per version
// Tail is shared, a freed register is visible to every version
// Register 0 is never stored, never handed out
// checkpoint_o is combinational, the version current this cycle
// Roll-back refills from the commit head, all in-flight allocations return
////////////////////////////////////////
`default_nettype none

`include "rename_consts.svh"

module free_list (
    input  logic                        clk_i,
    input  logic                        rstn_i,               // Async reset, active low
    input  logic                        read_head_i,          // Allocation request
    input  logic                        add_free_register_i,  // Free request from commit
    input  rename_pkg::phreg_t          free_register_i,      // Register being freed
    input  logic                        do_checkpoint_i,      // Checkpoint after this rename
    input  logic                        do_recover_i,         // Branch mispredict
    input  logic                        delete_checkpoint_i,  // Retire oldest checkpoint
    input  rename_pkg::checkpoint_ptr_t recover_checkpoint_i, // Version to restore
    input  logic                        commit_read_head_i,   // Commit passes one allocation
    input  logic                        commit_roll_back_i,   // Exception, overrides all
    output rename_pkg::phreg_t          new_register_o,       // 0 when nothing allocated
    output rename_pkg::checkpoint_ptr_t checkpoint_o,
    output logic                        checkpoint_taken_o,
    output logic                        out_of_checkpoints_o,
    output logic                        empty_o
);

    rename_pkg::phreg_t          reg_table [`RN_NUM_FL_ENTRIES];   // Ring storage
    rename_pkg::fl_ptr_t         head [`RN_NUM_CHECKPOINTS];       // Read pointer per version
    rename_pkg::fl_count_t       num [`RN_NUM_CHECKPOINTS];        // Free count per version
    rename_pkg::fl_ptr_t         tail;                             // Shared write pointer
    rename_pkg::fl_ptr_t         commit_head;                      // Non-speculative head
    rename_pkg::checkpoint_ptr_t version_head;                     // Current version
    rename_pkg::checkpoint_ptr_t version_tail;                     // Oldest live version
    rename_pkg::checkpoint_ptr_t version_next;
    rename_pkg::checkpoint_ptr_t version_diff;
    rename_pkg::ckpt_count_t     num_checkpoints;
    rename_pkg::fl_count_t       num_cur;
    rename_pkg::fl_count_t       num_cur_next;
    logic                        write_enable;
    logic                        read_enable;
    logic                        checkpoint_enable;
    logic                        commit_read_enable;
    logic                        bypass;

    assign version_next    = version_head + 1'b1;
    assign version_diff    = version_head - version_tail;
    assign num_checkpoints = {1'b0, version_diff};     // Live checkpoints, modulo ring
    assign num_cur         = num[version_head];

    // One version must stay free for the copy
    assign checkpoint_enable = do_checkpoint_i & ~do_recover_i & ~commit_roll_back_i
                             & (num_checkpoints < (`RN_NUM_CHECKPOINTS - 1));

    // x0 mapping never comes back
    assign write_enable = add_free_register_i & (free_register_i != '0) & ~commit_roll_back_i;

    // Empty list still serves a register freed this cycle
    assign read_enable = read_head_i & ((num_cur != '0) | write_enable)
                       & ~do_recover_i & ~commit_roll_back_i;

    assign commit_read_enable = commit_read_head_i & ~commit_roll_back_i;
    assign bypass             = (num_cur == '0) & write_enable;
    assign num_cur_next       = num_cur + write_enable - read_enable;

    ////////////////////////////////////////
    // Ring and version state
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RN_NUM_FL_ENTRIES; i++) begin
                reg_table[i] <= rename_pkg::phreg_t'(`RN_NUM_ISA_REGS + i); // 32..63 in order
            end
            for (int v = 0; v < `RN_NUM_CHECKPOINTS; v++) begin
                head[v] <= '0;
                num[v]  <= '0;
            end
            num[0]       <= rename_pkg::fl_count_t'(`RN_NUM_FL_ENTRIES);  // Full list
            tail         <= '0;                                           // Full, wraps onto head
            commit_head  <= '0;
            version_head <= '0;
            version_tail <= '0;
        end else if (commit_roll_back_i) begin
            // Back to version 0, every committed free register available
            version_head <= '0;
            version_tail <= '0;
            head[0]      <= commit_head;
            num[0]       <= rename_pkg::fl_count_t'(`RN_NUM_FL_ENTRIES);
        end else begin
            version_tail <= version_tail + delete_checkpoint_i;
            tail         <= tail + write_enable;
            commit_head  <= commit_head + commit_read_enable;

            if (write_enable) begin
                reg_table[tail] <= free_register_i;
            end
            // Freed register counts in every version
            for (int v = 0; v < `RN_NUM_CHECKPOINTS; v++) begin
                num[v] <= num[v] + write_enable;
            end

            if (do_recover_i) begin
                version_head <= recover_checkpoint_i;   // Later versions dropped
            end else begin
                head[version_head] <= head[version_head] + read_enable;
                num[version_head]  <= num_cur_next;     // Overrides the loop above
                if (checkpoint_enable) begin
                    // New version starts from state after this rename
                    version_head       <= version_next;
                    head[version_next] <= head[version_head] + read_enable;
                    num[version_next]  <= num_cur_next;
                end
            end
        end
    end

    // Head entry, or the freed register when the ring is empty
    assign new_register_o = !read_enable ? '0
                          : (bypass ? free_register_i : reg_table[head[version_head]]);

    assign checkpoint_o         = version_head;
    assign checkpoint_taken_o   = checkpoint_enable;
    assign out_of_checkpoints_o = (num_checkpoints == (`RN_NUM_CHECKPOINTS - 1));
    assign empty_o              = (num_cur == '0) & ~write_enable;

endmodule

`default_nettype wire

// File: hw/rename_consts.svh
////////////////////////////////////////
// Sizes of the rename stage
// All counts must stay powers of two, the ring pointers wrap freely
// Free-list depth is physical minus architectural registers
////////////////////////////////////////
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural registers, x0 included
`define RN_NUM_ISA_REGS      32
// Physical register file size
`define RN_NUM_PHYS_REGS     64
// Entries of the free-list ring
`define RN_NUM_FL_ENTRIES    (`RN_NUM_PHYS_REGS - `RN_NUM_ISA_REGS)
// Speculative versions of map and free list
`define RN_NUM_CHECKPOINTS   4

`endif

// File: hw/rename_map.sv
////////////////////////////////////////
// Map table, one speculative copy per version plus a committed copy
// Version label comes from the free list, no own version state
// Entry 0 is never written, x0 stays on physical 0
////////////////////////////////////////
`default_nettype none

`include "rename_consts.svh"

module rename_map (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  rename_pkg::areg_t           src1_areg_i,
    input  rename_pkg::areg_t           src2_areg_i,
    input  rename_pkg::areg_t           dst_areg_i,
    input  logic                        alloc_i,              // Destination allocated
    input  rename_pkg::phreg_t          new_preg_i,
    input  rename_pkg::checkpoint_ptr_t version_i,            // Current version
    input  logic                        checkpoint_taken_i,   // Copy into next version
    input  logic                        do_recover_i,
    input  rename_pkg::checkpoint_ptr_t recover_checkpoint_i,
    input  logic                        commit_valid_i,
    input  rename_pkg::areg_t           commit_dst_areg_i,
    input  rename_pkg::phreg_t          commit_dst_preg_i,
    input  logic                        commit_roll_back_i,
    output rename_pkg::phreg_t          src1_preg_o,
    output rename_pkg::phreg_t          src2_preg_o,
    output rename_pkg::phreg_t          old_dst_preg_o        // Mapping being replaced
);

    rename_pkg::phreg_t          spec_map [`RN_NUM_CHECKPOINTS][`RN_NUM_ISA_REGS];
    rename_pkg::phreg_t          commit_map [`RN_NUM_ISA_REGS];
    rename_pkg::phreg_t          cur_map_next [`RN_NUM_ISA_REGS];   // Current copy after write
    rename_pkg::checkpoint_ptr_t rd_version;
    rename_pkg::checkpoint_ptr_t next_version;
    logic                        write_enable;
    logic                        commit_write;

    // Restored table already visible in the recover cycle
    assign rd_version   = do_recover_i ? recover_checkpoint_i : version_i;
    assign next_version = version_i + 1'b1;

    assign write_enable = alloc_i & (dst_areg_i != '0) & ~do_recover_i;
    assign commit_write = commit_valid_i & (commit_dst_areg_i != '0);

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////
    assign src1_preg_o    = spec_map[rd_version][src1_areg_i];
    assign src2_preg_o    = spec_map[rd_version][src2_areg_i];
    assign old_dst_preg_o = spec_map[rd_version][dst_areg_i];

    always_comb begin
        cur_map_next = spec_map[version_i];
        if (write_enable) begin
            cur_map_next[dst_areg_i] = new_preg_i;
        end
    end

    ////////////////////////////////////////
    // Table update
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Identity mapping everywhere
            for (int r = 0; r < `RN_NUM_ISA_REGS; r++) begin
                commit_map[r] <= rename_pkg::phreg_t'(r);
                for (int v = 0; v < `RN_NUM_CHECKPOINTS; v++) begin
                    spec_map[v][r] <= rename_pkg::phreg_t'(r);
                end
            end
        end else if (commit_roll_back_i) begin
            spec_map[0] <= commit_map;              // Free list restarts at version 0 too
        end else begin
            if (commit_write) begin
                commit_map[commit_dst_areg_i] <= commit_dst_preg_i;
            end
            spec_map[version_i] <= cur_map_next;
            if (checkpoint_taken_i) begin
                spec_map[next_version] <= cur_map_next;  // Includes this cycle's rename
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rename_pkg.sv
////////////////////////////////////////
// Types shared by the rename stage
// Widths follow the constants header
////////////////////////////////////////
`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

    // Architectural register index
    typedef logic [$clog2(`RN_NUM_ISA_REGS)-1:0]     areg_t;
    // Physical register index
    typedef logic [$clog2(`RN_NUM_PHYS_REGS)-1:0]    phreg_t;
    // Checkpoint label, wraps modulo the checkpoint count
    typedef logic [$clog2(`RN_NUM_CHECKPOINTS)-1:0]  checkpoint_ptr_t;
    // Position in the free-list ring
    typedef logic [$clog2(`RN_NUM_FL_ENTRIES)-1:0]   fl_ptr_t;

    // One bit wider than the pointer, a full list must fit
    typedef logic [$clog2(`RN_NUM_FL_ENTRIES):0]     fl_count_t;
    // Live checkpoints
    typedef logic [$clog2(`RN_NUM_CHECKPOINTS):0]    ckpt_count_t;

endpackage

`default_nettype wire

// File: hw/rename_unit.sv
////////////////////////////////////////
// Rename stage top, one instruction per cycle
// All strobes single cycle, no handshake
// On stall the rename source must hold its request
////////////////////////////////////////
`default_nettype none

module rename_unit (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // Rename
    input  logic                        rename_valid_i,
    input  rename_pkg::areg_t           src1_areg_i,
    input  rename_pkg::areg_t           src2_areg_i,
    input  rename_pkg::areg_t           dst_areg_i,
    input  logic                        dst_valid_i,
    // Branch control
    input  logic                        do_checkpoint_i,
    input  logic                        do_recover_i,
    input  rename_pkg::checkpoint_ptr_t recover_checkpoint_i,
    input  logic                        delete_checkpoint_i,
    // Commit
    input  logic                        commit_valid_i,
    input  rename_pkg::areg_t           commit_dst_areg_i,
    input  rename_pkg::phreg_t          commit_dst_preg_i,
    input  rename_pkg::phreg_t          commit_old_preg_i,     // Freed at commit
    input  logic                        commit_roll_back_i,
    // Results
    output rename_pkg::phreg_t          src1_preg_o,
    output rename_pkg::phreg_t          src2_preg_o,
    output rename_pkg::phreg_t          dst_preg_o,            // 0 without allocation
    output rename_pkg::phreg_t          old_dst_preg_o,
    output rename_pkg::checkpoint_ptr_t checkpoint_o,
    output logic                        stall_o,
    output logic                        out_of_checkpoints_o
);

    rename_pkg::phreg_t          new_preg;
    rename_pkg::checkpoint_ptr_t version;
    logic                        checkpoint_taken;
    logic                        empty;
    logic                        alloc_req;
    logic                        alloc;
    logic                        free_req;

    assign alloc_req = rename_valid_i & dst_valid_i & (dst_areg_i != '0);   // x0 never renamed
    assign free_req  = commit_valid_i & (commit_dst_areg_i != '0);
    // Same gating as the free-list read
    assign alloc     = alloc_req & ~empty & ~do_recover_i & ~commit_roll_back_i;

    assign dst_preg_o   = alloc ? new_preg : '0;
    assign checkpoint_o = version;
    assign stall_o      = empty;       // Empty and nothing freed this cycle

    free_list u_free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (alloc_req),
        .add_free_register_i  (free_req),
        .free_register_i      (commit_old_preg_i),
        .do_checkpoint_i      (do_checkpoint_i),
        .do_recover_i         (do_recover_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .commit_read_head_i   (free_req),
        .commit_roll_back_i   (commit_roll_back_i),
        .new_register_o       (new_preg),
        .checkpoint_o         (version),
        .checkpoint_taken_o   (checkpoint_taken),
        .out_of_checkpoints_o (out_of_checkpoints_o),
        .empty_o              (empty)
    );

    rename_map u_rename_map (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .src1_areg_i          (src1_areg_i),
        .src2_areg_i          (src2_areg_i),
        .dst_areg_i           (dst_areg_i),
        .alloc_i              (alloc),
        .new_preg_i           (new_preg),
        .version_i            (version),
        .checkpoint_taken_i   (checkpoint_taken),
        .do_recover_i         (do_recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .commit_valid_i       (commit_valid_i),
        .commit_dst_areg_i    (commit_dst_areg_i),
        .commit_dst_preg_i    (commit_dst_preg_i),
        .commit_roll_back_i   (commit_roll_back_i),
        .src1_preg_o          (src1_preg_o),
        .src2_preg_o          (src2_preg_o),
        .old_dst_preg_o       (old_dst_preg_o)
    );

endmodule

`default_nettype wire

// File: rename.f
+incdir+hw
hw/rename_pkg.sv
hw/free_list.sv
hw/rename_map.sv
hw/rename_unit.sv
sim/rename_unit_asserts.sv
sim/tb_rename_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the rename testbench with Verilator and run it
# The exit status of the simulation is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f rename.f \
    --top-module tb_rename_unit \
    --Mdir obj_dir \
    -o tb_rename_unit

./obj_dir/tb_rename_unit

// File: sim/rename_unit_asserts.sv
////////////////////////////////////////
// Port checks for the rename stage, bound into every rename_unit
// Reports through failing assertions only
////////////////////////////////////////
`default_nettype none

module rename_unit_asserts (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        rename_valid_i,
    input  logic                        dst_valid_i,
    input  rename_pkg::areg_t           dst_areg_i,
    input  rename_pkg::areg_t           src1_areg_i,
    input  logic                        do_recover_i,
    input  logic                        commit_roll_back_i,
    input  rename_pkg::phreg_t          src1_preg_o,
    input  rename_pkg::phreg_t          dst_preg_o,
    input  logic                        stall_o,
    input  logic                        out_of_checkpoints_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic alloc;    // Allocation happens this cycle

    assign alloc = rename_valid_i & dst_valid_i & (dst_areg_i != '0)
                 & ~stall_o & ~do_recover_i & ~commit_roll_back_i;

    // An allocation never hands out the x0 register
    alloc_nonzero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        alloc |-> (dst_preg_o != '0))
        else $error("allocation returned physical register 0");

    // Full free list and no checkpoints right after reset
    reset_state: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> (!stall_o && !out_of_checkpoints_o))
        else $error("stall or checkpoint flag set after reset");

    x0_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (src1_areg_i == '0) |-> (src1_preg_o == '0))     // x0 pinned to preg 0
        else $error("x0 source not mapped to physical register 0");

endmodule

bind rename_unit rename_unit_asserts u_asserts (
    .clk_i                (clk_i),
    .rstn_i               (rstn_i),
    .rename_valid_i       (rename_valid_i),
    .dst_valid_i          (dst_valid_i),
    .dst_areg_i           (dst_areg_i),
    .src1_areg_i          (src1_areg_i),
    .do_recover_i         (do_recover_i),
    .commit_roll_back_i   (commit_roll_back_i),
    .src1_preg_o          (src1_preg_o),
    .dst_preg_o           (dst_preg_o),
    .stall_o              (stall_o),
    .out_of_checkpoints_o (out_of_checkpoints_o)
);

`default_nettype wire

// File: sim/tb_rename_unit.sv
////////////////////////////////////////
// Testbench for the rename stage, directed phases then LFSR traffic
// Inputs change 1 ns after the rising edge, outputs compared at the falling edge
// Commit values are free, only the free-list depth bounds the frees
////////////////////////////////////////
`default_nettype none

`include "rename_consts.svh"

module tb_rename_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_CYCLES = 600;
    localparam int TEST_CYCLES   = RANDOM_CYCLES + 140;   // Reset and directed phases included

    logic clk = 1'b0;
    logic rstn;
    logic rename_valid, dst_valid, do_checkpoint, do_recover, delete_checkpoint;
    logic commit_valid, commit_roll_back;
    rename_pkg::areg_t           src1_areg, src2_areg, dst_areg, commit_dst_areg;
    rename_pkg::phreg_t          commit_dst_preg, commit_old_preg;
    rename_pkg::checkpoint_ptr_t recover_checkpoint;
    rename_pkg::phreg_t          src1_preg, src2_preg, dst_preg, old_dst_preg;
    rename_pkg::checkpoint_ptr_t checkpoint;
    logic stall, out_of_checkpoints;

    // Reference state
    rename_pkg::phreg_t          m_map [`RN_NUM_CHECKPOINTS][`RN_NUM_ISA_REGS];  // Per version
    rename_pkg::phreg_t          c_map [`RN_NUM_ISA_REGS];                       // Committed
    rename_pkg::phreg_t          flq [`RN_NUM_CHECKPOINTS][$];   // Free queue per version
    rename_pkg::phreg_t          cq [$];                         // Committed free queue
    rename_pkg::checkpoint_ptr_t m_vh, m_vt;                     // Current and oldest version
    logic [15:0]                 lfsr;
    logic                        checking;
    rename_pkg::checkpoint_ptr_t saved;

    always #2 clk = ~clk;   // 4 ns period

    rename_unit uut (
        .clk_i(clk), .rstn_i(rstn),
        .rename_valid_i(rename_valid), .src1_areg_i(src1_areg), .src2_areg_i(src2_areg),
        .dst_areg_i(dst_areg), .dst_valid_i(dst_valid),
        .do_checkpoint_i(do_checkpoint), .do_recover_i(do_recover),
        .recover_checkpoint_i(recover_checkpoint), .delete_checkpoint_i(delete_checkpoint),
        .commit_valid_i(commit_valid), .commit_dst_areg_i(commit_dst_areg),
        .commit_dst_preg_i(commit_dst_preg), .commit_old_preg_i(commit_old_preg),
        .commit_roll_back_i(commit_roll_back),
        .src1_preg_o(src1_preg), .src2_preg_o(src2_preg), .dst_preg_o(dst_preg),
        .old_dst_preg_o(old_dst_preg), .checkpoint_o(checkpoint),
        .stall_o(stall), .out_of_checkpoints_o(out_of_checkpoints)
    );

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[6:0], lfsr[0]};                       // One step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic set_idle();
        {rename_valid, dst_valid, do_checkpoint, do_recover, delete_checkpoint} = '0;
        {commit_valid, commit_roll_back} = '0;
        {src1_areg, src2_areg, dst_areg, commit_dst_areg} = '0;
        {commit_dst_preg, commit_old_preg, recover_checkpoint} = '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        set_idle();
    endtask

    task automatic rename_op(input logic [4:0] dst, input logic [4:0] s1, input logic [4:0] s2);
        rename_valid = 1'b1;
        dst_valid    = 1'b1;
        dst_areg     = dst;
        src1_areg    = s1;
        src2_areg    = s2;
    endtask

    // Every live version must have room, else the ring would overwrite
    function automatic logic room_to_free();
        rename_pkg::checkpoint_ptr_t v;
        v = m_vt;
        for (int i = 0; i < `RN_NUM_CHECKPOINTS; i++) begin
            if (flq[v].size() >= `RN_NUM_FL_ENTRIES) return 1'b0;
            if (v == m_vh) break;
            v = v + 1'b1;
        end
        return 1'b1;
    endfunction

    task automatic commit_op(input logic [4:0] areg, input logic [5:0] preg, input logic [5:0] old);
        if (room_to_free()) begin
            commit_valid    = 1'b1;
            commit_dst_areg = areg;
            commit_dst_preg = (preg == '0) ? 6'd1 : preg;
            commit_old_preg = (old == '0) ? 6'd1 : old;   // Never free x0's register
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic frees_now();
        return commit_valid && (commit_dst_areg != '0) && (commit_old_preg != '0)
            && !commit_roll_back;
    endfunction

    function automatic logic alloc_now();
        return rename_valid && dst_valid && (dst_areg != '0) && !do_recover && !commit_roll_back
            && ((flq[m_vh].size() != 0) || frees_now());
    endfunction

    function automatic void predict_outputs(
        output rename_pkg::phreg_t e_src1, output rename_pkg::phreg_t e_src2,
        output rename_pkg::phreg_t e_dst, output rename_pkg::phreg_t e_old,
        output logic e_stall, output logic e_ooc);
        rename_pkg::checkpoint_ptr_t rd;
        rd     = do_recover ? recover_checkpoint : m_vh;   // Restored table seen at once
        e_src1 = m_map[rd][src1_areg];
        e_src2 = m_map[rd][src2_areg];
        e_old  = m_map[rd][dst_areg];
        e_dst  = '0;
        if (alloc_now()) begin
            e_dst = (flq[m_vh].size() != 0) ? flq[m_vh][0] : commit_old_preg;  // Bypass
        end
        e_stall = (flq[m_vh].size() == 0) && !frees_now();
        e_ooc   = ((m_vh - m_vt) == 2'd3);
    endfunction

    task automatic model_reset();
        m_vh = '0;
        m_vt = '0;
        cq.delete();
        for (int v = 0; v < `RN_NUM_CHECKPOINTS; v++) begin
            flq[v].delete();
        end
        for (int r = 0; r < `RN_NUM_ISA_REGS; r++) begin
            c_map[r] = rename_pkg::phreg_t'(r);
            for (int v = 0; v < `RN_NUM_CHECKPOINTS; v++) m_map[v][r] = rename_pkg::phreg_t'(r);
            flq[0].push_back(rename_pkg::phreg_t'(r + `RN_NUM_ISA_REGS));
            cq.push_back(rename_pkg::phreg_t'(r + `RN_NUM_ISA_REGS));
        end
    endtask

    task automatic advance_model();
        logic                        alloc;
        logic                        frees;
        logic                        bypass;
        logic                        ckpt_en;
        rename_pkg::phreg_t          new_reg;
        rename_pkg::checkpoint_ptr_t nxt;
        alloc   = alloc_now();
        frees   = frees_now();
        bypass  = alloc && (flq[m_vh].size() == 0);
        ckpt_en = do_checkpoint && !do_recover && !commit_roll_back && ((m_vh - m_vt) < 2'd3);
        nxt     = m_vh + 1'b1;
        new_reg = commit_old_preg;
        if (commit_roll_back) begin
            m_vh   = '0;                      // Everything back to committed state
            m_vt   = '0;
            flq[0] = cq;
            for (int r = 0; r < `RN_NUM_ISA_REGS; r++) m_map[0][r] = c_map[r];
        end else begin
            if (alloc && !bypass) new_reg = flq[m_vh].pop_front();
            if (frees) begin
                for (int v = 0; v < `RN_NUM_CHECKPOINTS; v++) begin
                    if (!(bypass && v == int'(m_vh))) flq[v].push_back(commit_old_preg);
                end
                void'(cq.pop_front());
                cq.push_back(commit_old_preg);
                c_map[commit_dst_areg] = commit_dst_preg;
            end
            m_vt = m_vt + delete_checkpoint;
            if (do_recover) begin
                m_vh = recover_checkpoint;
            end else begin
                if (alloc) m_map[m_vh][dst_areg] = new_reg;
                if (ckpt_en) begin
                    flq[nxt] = flq[m_vh];         // Copy includes this cycle's rename
                    for (int r = 0; r < `RN_NUM_ISA_REGS; r++) m_map[nxt][r] = m_map[m_vh][r];
                    m_vh = nxt;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstn) advance_model();
    end

    ////////////////////////////////////////
    // Comparison
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h at %0t", name, got, exp, $time);
            $display("test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    always @(negedge clk) begin
        rename_pkg::phreg_t e_src1, e_src2, e_dst, e_old;
        logic               e_stall, e_ooc;
        if (rstn && checking) begin
            predict_outputs(e_src1, e_src2, e_dst, e_old, e_stall, e_ooc);
            check_value("src1_preg_o", 8'(src1_preg), 8'(e_src1));
            check_value("src2_preg_o", 8'(src2_preg), 8'(e_src2));
            check_value("dst_preg_o", 8'(dst_preg), 8'(e_dst));
            check_value("old_dst_preg_o", 8'(old_dst_preg), 8'(e_old));
            check_value("checkpoint_o", 8'(checkpoint), 8'(m_vh));
            check_value("stall_o", 8'(stall), 8'(e_stall));
            check_value("out_of_checkpoints_o", 8'(out_of_checkpoints), 8'(e_ooc));
        end
    end

    initial begin
        #((TEST_CYCLES + 100) * 4);
        $display("test failed");
        $fatal(1, "Simulation timed out before the tests finished");
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        set_idle();
        rstn     = 1'b0;
        checking = 1'b0;
        lfsr     = 16'd30;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        rstn     = 1'b1;
        checking = 1'b1;

        for (int i = 1; i <= 8; i++) begin        // Fresh allocations 32 upward
            rename_op(5'(i), 5'(i - 1), 5'(i + 1));
            next_cycle();
        end
        rename_op(5'd0, 5'd1, 5'd2);              // x0 destination
        next_cycle();
        rename_op(5'd5, 5'd3, 5'd4);
        dst_valid = 1'b0;
        next_cycle();
        for (int i = 1; i <= 4; i++) begin        // Identity registers freed
            commit_op(5'(i), 6'(31 + i), 6'(i));
            next_cycle();
        end
        repeat (40) begin                         // Drain until stall
            rename_op(5'(rand_bits(5) | 5'd1), 5'(rand_bits(5)), 5'(rand_bits(5)));
            next_cycle();
        end
        rename_op(5'd7, 5'd7, 5'd0);              // Bypass of a same-cycle free
        commit_op(5'd9, 6'd40, 6'd9);
        next_cycle();
        repeat (12) begin
            commit_op(5'(rand_bits(5)), 6'(rand_bits(6)), 6'(rand_bits(6)));
            next_cycle();
        end

        rename_op(5'd3, 5'd1, 5'd2);              // Checkpoint, renames, recover
        do_checkpoint = 1'b1;
        saved = m_vh;                             // Label of the version frozen here
        next_cycle();
        repeat (6) begin
            rename_op(5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
            commit_op(5'(rand_bits(5)), 6'(rand_bits(6)), 6'(rand_bits(6)));
            next_cycle();
        end
        do_recover = 1'b1;
        recover_checkpoint = saved;
        next_cycle();

        repeat (4) begin                          // Fourth checkpoint is refused
            rename_op(5'(rand_bits(5)), 5'd3, 5'd5);
            do_checkpoint = 1'b1;
            next_cycle();
        end
        repeat (3) begin
            delete_checkpoint = 1'b1;
            next_cycle();
        end

        repeat (RANDOM_CYCLES) begin
            rename_valid = 1'(rand_bits(1));
            dst_valid    = 1'(rand_bits(1));
            dst_areg     = 5'(rand_bits(5));
            src1_areg    = 5'(rand_bits(5));
            src2_areg    = 5'(rand_bits(5));
            if (rand_bits(3) == 0) begin
                do_checkpoint = 1'b1;
            end else if (rand_bits(4) == 0 && m_vh != m_vt) begin
                do_recover = 1'b1;          // Only to a live version
                recover_checkpoint = m_vt + 2'(rand_bits(2)
                    % (int'(rename_pkg::checkpoint_ptr_t'(m_vh - m_vt)) + 1));
            end else if (rand_bits(4) == 0 && m_vh != m_vt) begin
                delete_checkpoint = 1'b1;
            end
            if (rand_bits(1) != 0) commit_op(5'(rand_bits(5)), 6'(rand_bits(6)), 6'(rand_bits(6)));
            if (rand_bits(6) == 0) commit_roll_back = 1'b1;
            next_cycle();
        end
        commit_roll_back = 1'b1;                  // Final roll-back and reuse
        next_cycle();
        repeat (4) begin
            rename_op(5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
            next_cycle();
        end
        next_cycle();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
